// File: common/core_pkg.sv
package core_pkg;

    // widths that carry a meaning across the pipeline
    typedef logic [31:0] word_t;     // data word, byte address or bit mask
    typedef logic [4:0]  reg_addr_t; // register-file index for writeback
    typedef logic [3:0]  mem_op_t;   // memory-operation code
    typedef logic [3:0]  wb_sel_t;   // writeback-source code

    // memory-operation codes, loads first and then stores
    localparam mem_op_t MEM_X   = 4'd0;
    localparam mem_op_t MEM_LB  = 4'd1;
    localparam mem_op_t MEM_LBU = 4'd2;
    localparam mem_op_t MEM_LH  = 4'd3;
    localparam mem_op_t MEM_LHU = 4'd4;
    localparam mem_op_t MEM_LW  = 4'd5;
    localparam mem_op_t MEM_SB  = 4'd6;
    localparam mem_op_t MEM_SH  = 4'd7;
    localparam mem_op_t MEM_SW  = 4'd8;

    // writeback-source codes
    localparam wb_sel_t WB_X   = 4'd0;
    localparam wb_sel_t WB_ALU = 4'd1;
    localparam wb_sel_t WB_MEM = 4'd2;
    localparam wb_sel_t WB_PC  = 4'd3;

    // a pc of all ones marks a bubble in every later stage
    localparam word_t REGPC_NOP = 32'hffff_ffff;

    // fill values used when a slot carries no instruction
    localparam word_t     BUBBLE_WORD    = 32'hffff_ffff;
    localparam reg_addr_t BUBBLE_WB_ADDR = 5'd0;

    // store masks act on the low bits of the addressed word
    localparam word_t MASK_BYTE = 32'h0000_00ff;
    localparam word_t MASK_HALF = 32'h0000_ffff;
    localparam word_t MASK_WORD = 32'hffff_ffff;

endpackage

// File: mem_stage/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  word_t     pc,
    input  word_t     alu_out,
    input  word_t     rs2_data,
    input  word_t     br_target,
    input  mem_op_t   mem_op,
    input  logic      rf_wen,
    input  wb_sel_t   wb_sel,
    input  reg_addr_t wb_addr,
    input  logic      br_flg,
    output logic      stall,
    output logic      cmd_start,
    output logic      cmd_write,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output word_t     mem_wmask,
    input  logic      cmd_ready,
    input  word_t     rdata,
    input  logic      rdata_valid,
    output word_t     out_read_data,
    output word_t     out_pc,
    output word_t     out_alu_out,
    output word_t     out_br_target,
    output logic      out_rf_wen,
    output logic      out_br_flg,
    output wb_sel_t   out_wb_sel,
    output reg_addr_t out_wb_addr
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_VALID
    } state_t;

    state_t    state, state_next;

    word_t     pc_m, alu_out_m, rs2_data_m, br_target_m;
    mem_op_t   mem_op_m;
    logic      rf_wen_m, br_flg_m;
    wb_sel_t   wb_sel_m;
    reg_addr_t wb_addr_m;

    word_t     save_pc, save_alu_out, save_rs2_data, save_br_target;
    mem_op_t   save_mem_op;
    logic      save_rf_wen, save_br_flg;
    wb_sel_t   save_wb_sel;
    reg_addr_t save_wb_addr;

    logic      cur_store, cur_load, save_store;
    logic      take_cur, take_save;

    word_t     read_data_next, pc_next, alu_out_next, br_target_next;
    logic      rf_wen_next, br_flg_next;
    wb_sel_t   wb_sel_next;
    reg_addr_t wb_addr_next;

    function automatic logic is_store_op(mem_op_t op);
        return op == MEM_SB || op == MEM_SH || op == MEM_SW;
    endfunction

    function automatic logic is_load_op(mem_op_t op);
        return op == MEM_LB || op == MEM_LBU || op == MEM_LH || op == MEM_LHU || op == MEM_LW;
    endfunction

    function automatic word_t wmask_of(mem_op_t op);
        return (op == MEM_SB) ? MASK_BYTE : (op == MEM_SH) ? MASK_HALF : MASK_WORD;
    endfunction

    function automatic word_t extend_load(mem_op_t op, word_t data);
        word_t ext;
        case (op)
            MEM_LB:  ext = {{24{data[7]}}, data[7:0]};
            MEM_LBU: ext = {24'h0, data[7:0]};
            MEM_LH:  ext = {{16{data[15]}}, data[15:0]};
            MEM_LHU: ext = {16'h0, data[15:0]};
            default: ext = data; // LW, or a load that was flushed while outstanding
        endcase
        return ext;
    endfunction

    // a flush from writeback turns whatever sits on the inputs into a bubble
    assign pc_m        = flush ? REGPC_NOP      : pc;
    assign alu_out_m   = flush ? BUBBLE_WORD    : alu_out;
    assign rs2_data_m  = flush ? BUBBLE_WORD    : rs2_data;
    assign br_target_m = flush ? BUBBLE_WORD    : br_target;
    assign mem_op_m    = flush ? MEM_X          : mem_op;
    assign rf_wen_m    = flush ? 1'b0           : rf_wen;
    assign wb_sel_m    = flush ? WB_X           : wb_sel;
    assign wb_addr_m   = flush ? BUBBLE_WB_ADDR : wb_addr;
    assign br_flg_m    = flush ? 1'b0           : br_flg;

    assign cur_store  = is_store_op(mem_op_m);
    assign cur_load   = is_load_op(mem_op_m);
    assign save_store = is_store_op(save_mem_op);

    always_comb begin
        state_next = state;
        cmd_start  = 1'b0;
        cmd_write  = 1'b0;
        mem_addr   = BUBBLE_WORD;
        mem_wdata  = BUBBLE_WORD;
        mem_wmask  = MASK_WORD;
        take_cur   = 1'b0;
        take_save  = 1'b0;
        case (state)
            S_IDLE: begin // issue straight from the inputs
                cmd_start = cur_store || cur_load;
                cmd_write = cur_store;
                mem_addr  = alu_out_m;
                mem_wdata = rs2_data_m;
                mem_wmask = wmask_of(mem_op_m);
                take_cur  = !(cur_store || cur_load) || (cur_store && cmd_ready);
                if ((cur_store || cur_load) && !cmd_ready) begin
                    state_next = S_WAIT_READY;
                end else if (cur_load) begin
                    state_next = S_WAIT_VALID;
                end
            end
            S_WAIT_READY: begin // retry the saved access until the RAM frees up
                cmd_start = cmd_ready;
                cmd_write = cmd_ready && save_store;
                mem_addr  = save_alu_out;
                mem_wdata = save_rs2_data;
                mem_wmask = wmask_of(save_mem_op);
                take_save = cmd_ready && save_store;
                if (cmd_ready) begin
                    state_next = save_store ? S_IDLE : S_WAIT_VALID;
                end
            end
            S_WAIT_VALID: begin
                take_save = rdata_valid;
                if (rdata_valid) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    // upstream may only advance on a cycle whose instruction leaves this stage
    assign stall = !(take_cur || take_save);

    always_comb begin
        read_data_next = BUBBLE_WORD;
        if (state == S_WAIT_VALID && rdata_valid) begin
            read_data_next = extend_load(save_mem_op, rdata);
        end
        if (take_cur) begin
            pc_next        = pc_m;
            alu_out_next   = alu_out_m;
            br_target_next = br_target_m;
            rf_wen_next    = rf_wen_m;
            br_flg_next    = br_flg_m;
            wb_sel_next    = wb_sel_m;
            wb_addr_next   = wb_addr_m;
        end else if (take_save) begin
            pc_next        = save_pc;
            alu_out_next   = save_alu_out;
            br_target_next = save_br_target;
            rf_wen_next    = save_rf_wen;
            br_flg_next    = save_br_flg;
            wb_sel_next    = save_wb_sel;
            wb_addr_next   = save_wb_addr;
        end else begin // stalled, so writeback sees a bubble
            pc_next        = REGPC_NOP;
            alu_out_next   = BUBBLE_WORD;
            br_target_next = BUBBLE_WORD;
            rf_wen_next    = 1'b0;
            br_flg_next    = 1'b0;
            wb_sel_next    = WB_X;
            wb_addr_next   = BUBBLE_WB_ADDR;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            out_pc     <= REGPC_NOP;
            out_rf_wen <= 1'b0;
            out_br_flg <= 1'b0;
            out_wb_sel <= WB_X;
        end else begin
            state      <= state_next;
            out_pc     <= pc_next;
            out_rf_wen <= rf_wen_next;
            out_br_flg <= br_flg_next;
            out_wb_sel <= wb_sel_next;
        end
    end

    always_ff @(posedge clk) begin
        if (flush || state == S_IDLE) begin // the flushed bubble replaces any saved copy
            save_pc        <= pc_m;
            save_alu_out   <= alu_out_m;
            save_rs2_data  <= rs2_data_m;
            save_br_target <= br_target_m;
            save_mem_op    <= mem_op_m;
            save_rf_wen    <= rf_wen_m;
            save_br_flg    <= br_flg_m;
            save_wb_sel    <= wb_sel_m;
            save_wb_addr   <= wb_addr_m;
        end
        out_read_data <= read_data_next;
        out_alu_out   <= alu_out_next;
        out_br_target <= br_target_next;
        out_wb_addr   <= wb_addr_next;
    end

    // read data may only return to a load that is waiting for it
    assert property (@(posedge clk) disable iff (!arst_n) rdata_valid |-> state == S_WAIT_VALID);

    assert property (@(posedge clk) disable iff (!arst_n)
        (state == S_IDLE && mem_op == MEM_X) |-> !stall);

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ns

module data_ram
    import core_pkg::*;
#(
    parameter int RAM_ADDR_W  = 8,
    parameter int RAM_LATENCY = 2
)
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cmd_start,
    input  logic  cmd_write,
    input  word_t mem_addr,
    input  word_t mem_wdata,
    input  word_t mem_wmask,
    output logic  cmd_ready,
    output word_t rdata,
    output logic  rdata_valid
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    word_t                 mem [DEPTH];
    logic [RAM_ADDR_W-1:0] word_idx;
    logic [2:0]            busy_cnt;
    logic                  rd_pending;
    logic                  accept;

    // byte offset bits are ignored, the RAM only knows words
    assign word_idx = mem_addr[RAM_ADDR_W+1:2];
    assign accept   = cmd_start && cmd_ready;

    assign cmd_ready   = (busy_cnt == 3'd0);
    assign rdata_valid = rd_pending && (busy_cnt == 3'd1); // last busy cycle

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt   <= 3'd0;
            rd_pending <= 1'b0;
        end else if (accept) begin
            busy_cnt   <= 3'(RAM_LATENCY);
            rd_pending <= !cmd_write;
        end else if (busy_cnt != 3'd0) begin
            busy_cnt <= busy_cnt - 3'd1;
            if (busy_cnt == 3'd1) begin
                rd_pending <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (accept) begin
            if (cmd_write) begin
                mem[word_idx] <= (mem[word_idx] & ~mem_wmask) | (mem_wdata & mem_wmask);
            end else begin
                rdata <= mem[word_idx]; // held until the busy time runs out
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(cmd_ready && rdata_valid));

    // an accepted read answers exactly at the end of its busy time
    assert property (@(posedge clk) disable iff (!arst_n)
        (accept && !cmd_write) |-> ##(RAM_LATENCY) rdata_valid);

endmodule

// File: verilog/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem
    import core_pkg::*;
#(
    parameter int RAM_ADDR_W  = 8,
    parameter int RAM_LATENCY = 2
)
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  word_t     pc,
    input  word_t     alu_out,
    input  word_t     rs2_data,
    input  word_t     br_target,
    input  mem_op_t   mem_op,
    input  logic      rf_wen,
    input  wb_sel_t   wb_sel,
    input  reg_addr_t wb_addr,
    input  logic      br_flg,
    output logic      stall,
    output word_t     out_read_data,
    output word_t     out_pc,
    output word_t     out_alu_out,
    output word_t     out_br_target,
    output logic      out_rf_wen,
    output logic      out_br_flg,
    output wb_sel_t   out_wb_sel,
    output reg_addr_t out_wb_addr
);

    logic  cmd_start, cmd_write, cmd_ready, rdata_valid;
    word_t mem_addr, mem_wdata, mem_wmask, rdata;

    mem_stage mem_stage_inst (
        .clk, .arst_n, .flush,
        .pc, .alu_out, .rs2_data, .br_target,
        .mem_op, .rf_wen, .wb_sel, .wb_addr, .br_flg,
        .stall,
        .cmd_start, .cmd_write, .mem_addr, .mem_wdata, .mem_wmask,
        .cmd_ready, .rdata, .rdata_valid,
        .out_read_data, .out_pc, .out_alu_out, .out_br_target,
        .out_rf_wen, .out_br_flg, .out_wb_sel, .out_wb_addr
    );

    data_ram #(
        .RAM_ADDR_W  (RAM_ADDR_W),
        .RAM_LATENCY (RAM_LATENCY)
    ) data_ram_inst (
        .clk, .arst_n,
        .cmd_start, .cmd_write, .mem_addr, .mem_wdata, .mem_wmask,
        .cmd_ready, .rdata, .rdata_valid
    );

endmodule

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/1ns

module mem_subsystem_tb
    import core_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int RAM_ADDR_W  = 8;
    localparam int RAM_LATENCY = 2;

    typedef struct {
        logic      flush;
        mem_op_t   op;
        word_t     addr;
        word_t     data;
        word_t     pc;
        reg_addr_t wb_addr;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        logic      br_flg;
        word_t     br_target;
        logic      no_gap;
    } row_t;

    logic      clk, arst_n, flush, rf_wen, br_flg, stall;
    word_t     pc, alu_out, rs2_data, br_target;
    mem_op_t   mem_op;
    wb_sel_t   wb_sel;
    reg_addr_t wb_addr;
    word_t     out_read_data, out_pc, out_alu_out, out_br_target;
    logic      out_rf_wen, out_br_flg;
    wb_sel_t   out_wb_sel;
    reg_addr_t out_wb_addr;

    row_t      rows[$];
    word_t     model_mem [2**RAM_ADDR_W];
    word_t     lcg_state = 32'h103c5cbc;
    int        ram_busy; // clock edges left until the RAM takes a new command

    mem_subsystem #(
        .RAM_ADDR_W  (RAM_ADDR_W),
        .RAM_LATENCY (RAM_LATENCY)
    ) mem_subsystem_inst (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .pc(pc), .alu_out(alu_out), .rs2_data(rs2_data), .br_target(br_target),
        .mem_op(mem_op), .rf_wen(rf_wen), .wb_sel(wb_sel), .wb_addr(wb_addr),
        .br_flg(br_flg), .stall(stall),
        .out_read_data(out_read_data), .out_pc(out_pc), .out_alu_out(out_alu_out),
        .out_br_target(out_br_target), .out_rf_wen(out_rf_wen), .out_br_flg(out_br_flg),
        .out_wb_sel(out_wb_sel), .out_wb_addr(out_wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t lcg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t store_mask(mem_op_t op);
        case (op)
            MEM_SB:  return MASK_BYTE;
            MEM_SH:  return MASK_HALF;
            default: return MASK_WORD;
        endcase
    endfunction

    // LB and LH copy the top bit of the loaded part, LBU and LHU fill with zeros
    function automatic word_t load_value(mem_op_t op, word_t w);
        case (op)
            MEM_LB:  return {{24{w[7]}}, w[7:0]};
            MEM_LBU: return {24'h0, w[7:0]};
            MEM_LH:  return {{16{w[15]}}, w[15:0]};
            MEM_LHU: return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic add_row(logic fl, mem_op_t op, word_t addr, word_t data, word_t pc_v,
                           reg_addr_t wba, logic wen, wb_sel_t sel, logic bf, word_t bt,
                           logic ng);
        row_t r;
        r = '{fl, op, addr, data, pc_v, wba, wen, sel, bf, bt, ng};
        rows.push_back(r);
    endtask

    task automatic check(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one clock edge brings a busy RAM one cycle closer to ready
    task automatic tick_busy();
        if (ram_busy > 0) begin
            ram_busy = ram_busy - 1;
        end
    endtask

    task automatic drive_idle();
        flush     = 1'b0;
        pc        = REGPC_NOP;
        alu_out   = '0;
        rs2_data  = '0;
        br_target = '0;
        mem_op    = MEM_X;
        rf_wen    = 1'b0;
        wb_sel    = WB_X;
        wb_addr   = '0;
        br_flg    = 1'b0;
    endtask

    task automatic run_row(row_t r);
        logic  stalled;
        logic  exp_stall;
        word_t exp_data;
        int    idx;
        idx       = r.addr[RAM_ADDR_W+1:2];
        stalled   = 1'b0;
        exp_stall = (ram_busy > 0); // a store waits only while the RAM is busy
        exp_data  = 32'hffff_ffff; // no load data for anything but a load
        flush     = r.flush;
        mem_op    = r.op;
        alu_out   = r.addr;
        rs2_data  = r.data;
        pc        = r.pc;
        wb_addr   = r.wb_addr;
        rf_wen    = r.rf_wen;
        wb_sel    = r.wb_sel;
        br_flg    = r.br_flg;
        br_target = r.br_target;
        #2;
        while (stall) begin // inputs stay put while the stage is busy
            stalled = 1'b1;
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        if (r.flush) begin
            check("out_pc", out_pc, REGPC_NOP);
            check("out_rf_wen", out_rf_wen, 0);
            check("out_wb_sel", out_wb_sel, WB_X);
            check("out_br_flg", out_br_flg, 0);
            check("stall", stalled, 0);
            tick_busy();
        end else begin
            check("out_pc", out_pc, r.pc);
            check("out_alu_out", out_alu_out, r.addr);
            check("out_rf_wen", out_rf_wen, r.rf_wen);
            check("out_wb_sel", out_wb_sel, r.wb_sel);
            check("out_wb_addr", out_wb_addr, r.wb_addr);
            check("out_br_flg", out_br_flg, r.br_flg);
            check("out_br_target", out_br_target, r.br_target);
            if (r.op == MEM_SB || r.op == MEM_SH || r.op == MEM_SW) begin
                model_mem[idx] = (model_mem[idx] & ~store_mask(r.op))
                               | (r.data & store_mask(r.op));
                check("stall", stalled, exp_stall);
                ram_busy = RAM_LATENCY; // the store was accepted one edge ago
            end else if (r.op != MEM_X) begin
                exp_data = load_value(r.op, model_mem[idx]);
                check("stall", stalled, 1);
                ram_busy = 0; // read data comes back in the last busy cycle
            end else begin
                check("stall", stalled, 0);
                tick_busy();
            end
        end
        check("out_read_data", out_read_data, exp_data);
    endtask

    initial begin
        arst_n   = 1'b0;
        ram_busy = 0;
        drive_idle();
        for (int i = 0; i < 2**RAM_ADDR_W; i++) begin
            model_mem[i] = '0;
        end
        // flush, op, address, store data, pc, wb_addr, rf_wen, wb_sel, br_flg, br_target, no gap
        add_row('0, MEM_X,  'h0000_1234, '0, 'h100, 5'd1, '1, WB_ALU, '0, '0, '0);
        add_row('0, MEM_X,  'h0000_0abc, '0, 'h104, 5'd2, '1, WB_PC,  '1, 'h240, '1);
        add_row('0, MEM_X,  'h8000_0001, '0, 'h108, 5'd3, '1, WB_ALU, '0, '0, '0);
        add_row('0, MEM_SW, 'h10, lcg(), 'h10c, 5'd0, '0, WB_X,   '0, '0, '0);
        add_row('0, MEM_LW, 'h10, '0,    'h110, 5'd4, '1, WB_MEM, '0, '0, '0);
        add_row('0, MEM_SW, 'h20, lcg(), 'h114, 5'd0, '0, WB_X,   '0, '0, '1);
        add_row('0, MEM_SB, 'h20, lcg(), 'h118, 5'd0, '0, WB_X,   '0, '0, '1);
        add_row('0, MEM_LW, 'h20, '0,    'h11c, 5'd5, '1, WB_MEM, '0, '0, '1);
        add_row('0, MEM_SH, 'h20, lcg(), 'h120, 5'd0, '0, WB_X,   '0, '0, '1);
        add_row('0, MEM_LW, 'h20, '0,    'h124, 5'd6, '1, WB_MEM, '0, '0, '0);
        add_row('0, MEM_SW,  'h30, 'h5a5a_80f0, 'h128, 5'd0, '0, WB_X, '0, '0, '0);
        add_row('0, MEM_LB,  'h30, '0, 'h12c, 5'd7,  '1, WB_MEM, '0, '0, '1);
        add_row('0, MEM_LBU, 'h30, '0, 'h130, 5'd8,  '1, WB_MEM, '0, '0, '0);
        add_row('0, MEM_LH,  'h30, '0, 'h134, 5'd9,  '1, WB_MEM, '0, '0, '1);
        add_row('0, MEM_LHU, 'h30, '0, 'h138, 5'd10, '1, WB_MEM, '0, '0, '0);
        add_row('0, MEM_SW,  'h34, 'ha5a5_7f0f, 'h13c, 5'd0, '0, WB_X, '0, '0, '1);
        add_row('0, MEM_LB,  'h34, '0, 'h140, 5'd11, '1, WB_MEM, '0, '0, '1);
        add_row('0, MEM_LH,  'h34, '0, 'h144, 5'd12, '1, WB_MEM, '0, '0, '0);
        add_row('1, MEM_X,  'h0000_0999, '0, 'h200, 5'd7, '1, WB_ALU, '1, 'h300, '0);
        add_row('1, MEM_SW, 'h40, lcg(), 'h204, 5'd0,  '0, WB_X,   '0, '0, '1);
        add_row('0, MEM_LW, 'h40, '0,    'h208, 5'd13, '1, WB_MEM, '0, '0, '0);
        add_row('0, MEM_SW, 'h44, lcg(), 'h20c, 5'd0,  '0, WB_X,   '0, '0, '1);
        add_row('1, MEM_SW, 'h44, lcg(), 'h210, 5'd0,  '0, WB_X,   '0, '0, '1);
        add_row('0, MEM_LW, 'h44, '0,    'h214, 5'd14, '1, WB_MEM, '0, '0, '0);
        add_row('0, MEM_X,  'h0000_0042, '0, 'h218, 5'd15, '1, WB_ALU, '0, '0, '0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #2;
        check("out_pc", out_pc, REGPC_NOP);
        check("out_rf_wen", out_rf_wen, 0);
        check("out_wb_sel", out_wb_sel, WB_X);
        check("stall", stall, 0);
        @(negedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
            if (!rows[i].no_gap) begin
                drive_idle();
                repeat ((lcg() >> 16) % 4) begin
                    @(negedge clk);
                    tick_busy();
                end
            end
        end
        $display("Test completed successfully");
        $finish;
    end

    // each row gets a generous budget of cycles on top of the reset time
    initial begin
        #1;
        repeat (rows.size() * 40 + 20) @(posedge clk);
        $display("The run timed out before all table rows were processed");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: mem_subsystem.f
common/core_pkg.sv
mem_stage/mem_stage.sv
verilog/data_ram.sv
verilog/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - common/core_pkg.sv
  - mem_stage/mem_stage.sv
  - verilog/data_ram.sv
  - verilog/mem_subsystem.sv
  - target: test
    files:
      - bench/mem_subsystem_tb.sv
